// File: tb.f
+incdir+source
source/tlb_cmd_pkg.sv
source/tlb_addr_pkg.sv
source/l2_tlb_flush_unit.sv
source/l2_tlb_t0_stage.sv
source/l2_tlb_entry_array.sv
source/l2_tlb_t1_stage.sv
source/l2_tlb.sv
sim/l2_tlb_assert.sv
sim/l2_tlb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the L2 TLB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module l2_tlb_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vl2_tlb_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

// File: sim/l2_tlb_tb.sv
// ############################
// L2 TLB testbench
// Drives refills, lookups and flushes,
// keeps a shadow copy of the entries
// and checks every lookup response
// ############################

`include "tlb_params.svh"

module l2_tlb_tb;

  import tlb_cmd_pkg::*;
  import tlb_addr_pkg::*;

  localparam int unsigned NumSets    = 1 << `L2_TLB_IDX_LEN;
  localparam int unsigned BusyLimit  = 40;
  localparam int unsigned DrainLimit = 10;
  localparam int unsigned PpnLen     = `L2_TLB_PPN_LEN;

  logic                        clk;
  logic                        rst_n;
  tlb_flush_e                  flush_type;
  logic [`L2_TLB_ASID_LEN-1:0] flush_asid;
  l2_vpn_u                     flush_vpn;
  logic                        refill_valid;
  l2_vpn_u                     refill_vpn;
  logic [`L2_TLB_ASID_LEN-1:0] refill_asid;
  logic [`L2_TLB_PPN_LEN-1:0]  refill_ppn;
  logic                        refill_global;
  logic                        lookup_valid;
  l2_vpn_u                     lookup_vpn;
  logic [`L2_TLB_ASID_LEN-1:0] lookup_asid;
  logic                        busy;
  logic                        resp_valid;
  logic                        resp_hit;
  logic [`L2_TLB_PPN_LEN-1:0]  resp_ppn;

  // Shadow copy of the entry array
  logic                        sh_valid  [NumSets];
  logic                        sh_global [NumSets];
  logic [`L2_TLB_ASID_LEN-1:0] sh_asid   [NumSets];
  logic [`L2_TLB_TAG_LEN-1:0]  sh_tag    [NumSets];
  logic [`L2_TLB_PPN_LEN-1:0]  sh_ppn    [NumSets];

  // Expected {hit, ppn} per issued lookup in issue order
  logic [PpnLen:0] exp_q[$];
  logic [PpnLen:0] exp_resp;

  int unsigned errors;
  int unsigned checks;
  int unsigned base_errors;
  int unsigned base_checks;
  int unsigned i;
  logic [31:0] rnd;
  l2_vpn_u     vpn_a;
  l2_vpn_u     vpn_b;

  l2_tlb uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .flush_type_i    (flush_type),
    .flush_asid_i    (flush_asid),
    .flush_vpn_i     (flush_vpn),
    .refill_valid_i  (refill_valid),
    .refill_vpn_i    (refill_vpn),
    .refill_asid_i   (refill_asid),
    .refill_ppn_i    (refill_ppn),
    .refill_global_i (refill_global),
    .lookup_valid_i  (lookup_valid),
    .lookup_vpn_i    (lookup_vpn),
    .lookup_asid_i   (lookup_asid),
    .busy_o          (busy),
    .resp_valid_o    (resp_valid),
    .resp_hit_o      (resp_hit),
    .resp_ppn_o      (resp_ppn)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Inputs change 2 units after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic l2_vpn_u make_vpn(input logic [`L2_TLB_TAG_LEN-1:0] tag,
                                       input int unsigned idx);
    l2_vpn_u v;
    v.fields.tag = tag;
    v.fields.idx = idx[`L2_TLB_IDX_LEN-1:0];
    return v;
  endfunction

  // Hit needs valid, same tag, and same ASID unless global
  function automatic logic [PpnLen:0] ref_lookup(input l2_vpn_u vpn,
                                                 input logic [`L2_TLB_ASID_LEN-1:0] asid);
    int unsigned s;
    logic        hit;
    s   = vpn.fields.idx;
    hit = sh_valid[s] && (sh_tag[s] == vpn.fields.tag) &&
          (sh_global[s] || (sh_asid[s] == asid));
    return {hit, sh_ppn[s]};
  endfunction

  task automatic wait_idle(input string what);
    int unsigned n;
    n = 0;
    while (busy && n < BusyLimit) begin
      next_cycle();
      n++;
    end
    if (busy) begin
      errors++;
      $display("timeout: busy_o still high %0d cycles after %s", n, what);
    end
  endtask

  task automatic drain_responses(input string what);
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0 && n < DrainLimit) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout: %0d lookup responses missing in %s", exp_q.size(), what);
      exp_q.delete();
    end
  endtask

  task automatic begin_test();
    base_errors = errors;
    base_checks = checks;
  endtask

  task automatic end_test(input string name);
    drain_responses(name);
    $display("%-14s %0d checks, %0d errors", name, checks - base_checks,
             errors - base_errors);
  endtask

  task automatic do_refill(input l2_vpn_u vpn, input logic [`L2_TLB_ASID_LEN-1:0] asid,
                           input logic [`L2_TLB_PPN_LEN-1:0] ppn, input logic glb);
    int unsigned s;
    s = vpn.fields.idx;
    refill_valid  = 1'b1;
    refill_vpn    = vpn;
    refill_asid   = asid;
    refill_ppn    = ppn;
    refill_global = glb;
    next_cycle();
    refill_valid  = 1'b0;
    sh_valid[s]   = 1'b1;
    sh_global[s]  = glb;
    sh_asid[s]    = asid;
    sh_tag[s]     = vpn.fields.tag;
    sh_ppn[s]     = ppn;
  endtask

  // Expected result is taken before the lookup enters the pipe
  task automatic issue_lookup(input l2_vpn_u vpn, input logic [`L2_TLB_ASID_LEN-1:0] asid);
    exp_q.push_back(ref_lookup(vpn, asid));
    lookup_valid = 1'b1;
    lookup_vpn   = vpn;
    lookup_asid  = asid;
    next_cycle();
    lookup_valid = 1'b0;
  endtask

  // Every stored page number with its own ASID
  task automatic lookup_all();
    int unsigned s;
    for (s = 0; s < NumSets; s++) begin
      issue_lookup(make_vpn(sh_tag[s], s), sh_asid[s]);
    end
  endtask

  task automatic start_flush(input tlb_flush_e kind, input logic [`L2_TLB_ASID_LEN-1:0] asid,
                             input l2_vpn_u vpn);
    int unsigned s;
    flush_type = kind;
    flush_asid = asid;
    flush_vpn  = vpn;
    next_cycle();
    flush_type = NoFlush;
    check_value("busy_o", busy, 1);
    for (s = 0; s < NumSets; s++) begin
      if (kind == FlushAll) begin
        sh_valid[s] = 1'b0;
      end else if (kind == FlushASID && !sh_global[s] && sh_asid[s] == asid) begin
        sh_valid[s] = 1'b0;
      end else if (kind == FlushPage && make_vpn(sh_tag[s], s) == vpn) begin
        sh_valid[s] = 1'b0;
      end
    end
  endtask

  // Refill and lookup while busy must both be dropped
  task automatic poke_while_busy(input l2_vpn_u vpn);
    check_value("busy_o", busy, 1);
    refill_valid  = 1'b1;
    refill_vpn    = make_vpn(vpn.fields.tag ^ 3, vpn.fields.idx);
    refill_asid   = 8'h5a;
    refill_ppn    = 20'hbad00;
    refill_global = 1'b1;
    lookup_valid  = 1'b1;
    lookup_vpn    = vpn;
    lookup_asid   = 8'h5a;
    next_cycle();
    refill_valid  = 1'b0;
    lookup_valid  = 1'b0;
  endtask

  // Response checker
  always @(negedge clk) begin
    if (rst_n && resp_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("response at %0t with no lookup outstanding", $time);
      end else begin
        exp_resp = exp_q.pop_front();
        check_value("resp_hit_o", resp_hit, exp_resp[PpnLen]);
        if (exp_resp[PpnLen]) begin
          check_value("resp_ppn_o", resp_ppn, exp_resp[PpnLen-1:0]);
        end
      end
    end
  end

  initial begin
    void'($urandom(32'h70aa_eccd));
    rst_n         = 1'b0;
    flush_type    = NoFlush;
    flush_asid    = '0;
    flush_vpn     = '0;
    refill_valid  = 1'b0;
    refill_vpn    = '0;
    refill_asid   = '0;
    refill_ppn    = '0;
    refill_global = 1'b0;
    lookup_valid  = 1'b0;
    lookup_vpn    = '0;
    lookup_asid   = '0;
    errors        = 0;
    checks        = 0;
    for (i = 0; i < NumSets; i++) begin
      sh_valid[i]  = 1'b0;
      sh_global[i] = 1'b0;
      sh_asid[i]   = '0;
      sh_tag[i]    = '0;
      sh_ppn[i]    = '0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Reset flush leaves every set empty
    begin_test();
    wait_idle("reset");
    for (i = 0; i < NumSets; i++) begin
      rnd = $urandom();
      issue_lookup(make_vpn(rnd[`L2_TLB_TAG_LEN-1:0], i), rnd[31:24]);
    end
    end_test("reset_miss");

    // Fill every set then look up each with own and foreign ASID back to back
    begin_test();
    for (i = 0; i < NumSets; i++) begin
      rnd = $urandom();
      do_refill(make_vpn(rnd[`L2_TLB_TAG_LEN-1:0], i), 8'd1 + rnd[17:16],
                $urandom(), rnd[19:18] == 2'b00);
    end
    for (i = 0; i < NumSets; i++) begin
      issue_lookup(make_vpn(sh_tag[i], i), sh_asid[i]);
      issue_lookup(make_vpn(sh_tag[i], i), sh_asid[i] ^ 8'h80);
    end
    end_test("refill_lookup");

    // Same set with a new tag
    begin_test();
    rnd   = $urandom();
    vpn_a = make_vpn(rnd[`L2_TLB_TAG_LEN-1:0], 3);
    vpn_b = make_vpn(rnd[`L2_TLB_TAG_LEN-1:0] ^ 1, 3);
    do_refill(vpn_a, 8'h11, $urandom(), 1'b0);
    do_refill(vpn_b, 8'h11, $urandom(), 1'b0);
    issue_lookup(vpn_a, 8'h11);
    issue_lookup(vpn_b, 8'h11);
    end_test("replace");

    begin_test();
    do_refill(make_vpn(16'h0a0a, 0), 8'd2, $urandom(), 1'b0);
    do_refill(make_vpn(16'h0b0b, 1), 8'd2, $urandom(), 1'b1);
    start_flush(FlushASID, 8'd2, '0);
    wait_idle("asid flush");
    lookup_all();
    end_test("flush_asid");

    begin_test();
    do_refill(make_vpn(16'h5555, 5), 8'h33, $urandom(), 1'b0);
    do_refill(make_vpn(16'h9999, 9), 8'h44, $urandom(), 1'b0);
    start_flush(FlushPage, 8'hff, make_vpn(16'h5555, 5));
    poke_while_busy(make_vpn(16'h9999, 9));
    wait_idle("page flush");
    lookup_all();
    end_test("flush_page");

    // Global entries go too
    begin_test();
    do_refill(make_vpn(16'h7777, 7), 8'h66, $urandom(), 1'b1);
    start_flush(FlushAll, '0, '0);
    wait_idle("total flush");
    lookup_all();
    end_test("flush_all");

    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim/l2_tlb_assert.sv
// ############################
// L2 TLB protocol assertions
// Response pulses and busy length
// ############################

`include "tlb_params.svh"

module l2_tlb_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic lookup_valid_i,
  input logic busy_i,
  input logic resp_valid_i
);

  // Longest busy stretch, walk plus pipeline
  localparam int unsigned MaxBusy = (1 << `L2_TLB_IDX_LEN) + 3;

  logic [7:0] busy_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_cnt_q <= '0;
    end else if (busy_i) begin
      busy_cnt_q <= busy_cnt_q + 8'd1;
    end else begin
      busy_cnt_q <= '0;
    end
  end

  // Dropped lookup gives no response
  ignored_lookup_silent: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lookup_valid_i && busy_i) |-> ##2 !resp_valid_i)
    else $error("response after a lookup dropped while busy");

  // One response cycle per accepted lookup
  resp_has_lookup: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |-> $past(lookup_valid_i && !busy_i, 2))
    else $error("response without an accepted lookup");

  lookup_has_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lookup_valid_i && !busy_i) |-> ##2 resp_valid_i)
    else $error("accepted lookup without a response");

  busy_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_cnt_q <= MaxBusy)
    else $error("busy_o held longer than a flush walk");

endmodule

bind l2_tlb l2_tlb_assert i_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .lookup_valid_i (lookup_valid_i),
  .busy_i         (busy_o),
  .resp_valid_i   (resp_valid_o)
);

// File: source/l2_tlb.sv
// ############################
// L2 TLB top level
// Direct-mapped second-level TLB
// Flush unit, t0, array and t1
// ############################

`include "tlb_params.svh"

module l2_tlb (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Flush request level
  input  tlb_cmd_pkg::tlb_flush_e     flush_type_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] flush_asid_i,
  input  tlb_addr_pkg::l2_vpn_u       flush_vpn_i,
  // Refill strobe
  input  logic                        refill_valid_i,
  input  tlb_addr_pkg::l2_vpn_u       refill_vpn_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] refill_asid_i,
  input  logic [`L2_TLB_PPN_LEN-1:0]  refill_ppn_i,
  input  logic                        refill_global_i,
  // Lookup strobe
  input  logic                        lookup_valid_i,
  input  tlb_addr_pkg::l2_vpn_u       lookup_vpn_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] lookup_asid_i,
  // Status and response
  output logic                        busy_o,
  output logic                        resp_valid_o,
  output logic                        resp_hit_o,
  output logic [`L2_TLB_PPN_LEN-1:0]  resp_ppn_o
);

  // Flush unit to t0
  logic                        flush_req_valid;
  tlb_cmd_pkg::tlb_flush_e     flush_type;
  logic [`L2_TLB_IDX_LEN-1:0]  flush_idx;
  logic                        flush_idx_cnt_en;

  // Array ports
  logic [`L2_TLB_IDX_LEN-1:0]  rd_idx;
  logic                        rd_valid;
  logic                        rd_global;
  logic [`L2_TLB_ASID_LEN-1:0] rd_asid;
  logic [`L2_TLB_TAG_LEN-1:0]  rd_tag;
  logic [`L2_TLB_PPN_LEN-1:0]  rd_ppn;
  logic                        wr_en;
  logic [`L2_TLB_IDX_LEN-1:0]  wr_idx;
  logic                        wr_global;
  logic [`L2_TLB_ASID_LEN-1:0] wr_asid;
  logic [`L2_TLB_TAG_LEN-1:0]  wr_tag;
  logic [`L2_TLB_PPN_LEN-1:0]  wr_ppn;
  logic                        inv_en;
  logic [`L2_TLB_IDX_LEN-1:0]  inv_idx;

  // t0 to t1
  logic [2:0]                  t1_op;
  logic [`L2_TLB_TAG_LEN-1:0]  t1_tag;
  logic [`L2_TLB_ASID_LEN-1:0] t1_asid;
  tlb_addr_pkg::l2_vpn_u       t1_flush_vpn;
  logic [`L2_TLB_IDX_LEN-1:0]  t1_idx;

  l2_tlb_flush_unit i_flush_unit (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_type_i       (flush_type_i),
    .flush_idx_cnt_en_i (flush_idx_cnt_en),
    .flush_idx_o        (flush_idx),
    .flush_type_o       (flush_type),
    .flush_req_valid_o  (flush_req_valid)
  );

  l2_tlb_t0_stage i_t0 (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_type_i       (flush_type_i),
    .flush_asid_i       (flush_asid_i),
    .flush_vpn_i        (flush_vpn_i),
    .refill_valid_i     (refill_valid_i),
    .refill_vpn_i       (refill_vpn_i),
    .refill_asid_i      (refill_asid_i),
    .refill_ppn_i       (refill_ppn_i),
    .refill_global_i    (refill_global_i),
    .lookup_valid_i     (lookup_valid_i),
    .lookup_vpn_i       (lookup_vpn_i),
    .lookup_asid_i      (lookup_asid_i),
    .flush_req_valid_i  (flush_req_valid),
    .flush_req_type_i   (flush_type),
    .flush_idx_i        (flush_idx),
    .flush_idx_cnt_en_o (flush_idx_cnt_en),
    .rd_idx_o           (rd_idx),
    .wr_en_o            (wr_en),
    .wr_idx_o           (wr_idx),
    .wr_global_o        (wr_global),
    .wr_asid_o          (wr_asid),
    .wr_tag_o           (wr_tag),
    .wr_ppn_o           (wr_ppn),
    .t1_op_o            (t1_op),
    .t1_tag_o           (t1_tag),
    .t1_asid_o          (t1_asid),
    .t1_flush_vpn_o     (t1_flush_vpn),
    .t1_idx_o           (t1_idx),
    .busy_o             (busy_o)
  );

  l2_tlb_entry_array i_array (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_idx_i    (rd_idx),
    .rd_valid_o  (rd_valid),
    .rd_global_o (rd_global),
    .rd_asid_o   (rd_asid),
    .rd_tag_o    (rd_tag),
    .rd_ppn_o    (rd_ppn),
    .wr_en_i     (wr_en),
    .wr_idx_i    (wr_idx),
    .wr_global_i (wr_global),
    .wr_asid_i   (wr_asid),
    .wr_tag_i    (wr_tag),
    .wr_ppn_i    (wr_ppn),
    .inv_en_i    (inv_en),
    .inv_idx_i   (inv_idx)
  );

  l2_tlb_t1_stage i_t1 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .t1_op_i        (t1_op),
    .t1_tag_i       (t1_tag),
    .t1_asid_i      (t1_asid),
    .t1_flush_vpn_i (t1_flush_vpn),
    .t1_idx_i       (t1_idx),
    .rd_valid_i     (rd_valid),
    .rd_global_i    (rd_global),
    .rd_asid_i      (rd_asid),
    .rd_tag_i       (rd_tag),
    .rd_ppn_i       (rd_ppn),
    .inv_en_o       (inv_en),
    .inv_idx_o      (inv_idx),
    .resp_valid_o   (resp_valid_o),
    .resp_hit_o     (resp_hit_o),
    .resp_ppn_o     (resp_ppn_o)
  );

endmodule

// File: source/l2_tlb_t1_stage.sv
// ############################
// L2 TLB stage t1
// Compares the read entry, registers
// the lookup response and issues
// flush invalidations
// ############################

`include "tlb_params.svh"

module l2_tlb_t1_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Stage register from t0
  input  logic [2:0]                  t1_op_i,
  input  logic [`L2_TLB_TAG_LEN-1:0]  t1_tag_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] t1_asid_i,
  input  tlb_addr_pkg::l2_vpn_u       t1_flush_vpn_i,
  input  logic [`L2_TLB_IDX_LEN-1:0]  t1_idx_i,
  // Entry read in t0
  input  logic                        rd_valid_i,
  input  logic                        rd_global_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] rd_asid_i,
  input  logic [`L2_TLB_TAG_LEN-1:0]  rd_tag_i,
  input  logic [`L2_TLB_PPN_LEN-1:0]  rd_ppn_i,
  // Invalidate write
  output logic                        inv_en_o,
  output logic [`L2_TLB_IDX_LEN-1:0]  inv_idx_o,
  // Lookup response
  output logic                        resp_valid_o,
  output logic                        resp_hit_o,
  output logic [`L2_TLB_PPN_LEN-1:0]  resp_ppn_o
);

  import tlb_cmd_pkg::*;

  logic                  lookup;
  logic                  asid_match;
  logic                  hit;
  tlb_addr_pkg::l2_vpn_u stored_vpn;

  assign lookup     = t1_op_i[2];
  assign asid_match = (rd_asid_i == t1_asid_i);

  // Global entries match any ASID
  assign hit = rd_valid_i & (rd_tag_i == t1_tag_i) & (asid_match | rd_global_i);

  // Full VPN of the stored entry
  always_comb begin
    stored_vpn.fields.tag = rd_tag_i;
    stored_vpn.fields.idx = t1_idx_i;
  end

  // Flush rules per type
  always_comb begin
    case (t1_op_i[1:0])
      FlushAll:  inv_en_o = 1'b1;
      FlushASID: inv_en_o = rd_valid_i & ~rd_global_i & asid_match;
      // ASID ignored for page flush
      FlushPage: inv_en_o = rd_valid_i & (stored_vpn.vpn == t1_flush_vpn_i.vpn);
      default:   inv_en_o = 1'b0;
    endcase
  end

  assign inv_idx_o = t1_idx_i;

  // One-cycle response pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_o <= 1'b0;
      resp_hit_o   <= 1'b0;
    end else begin
      resp_valid_o <= lookup;
      resp_hit_o   <= lookup & hit;
    end
  end

  // PPN only meaningful with a hit
  always_ff @(posedge clk_i) begin
    if (lookup) begin
      resp_ppn_o <= rd_ppn_i;
    end
  end

endmodule

// File: source/l2_tlb_entry_array.sv
// ############################
// L2 TLB entry array
// Direct-mapped entries, registered
// read and refill/invalidate writes
// ############################

`include "tlb_params.svh"

module l2_tlb_entry_array (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Read port, data one cycle later
  input  logic [`L2_TLB_IDX_LEN-1:0]  rd_idx_i,
  output logic                        rd_valid_o,
  output logic                        rd_global_o,
  output logic [`L2_TLB_ASID_LEN-1:0] rd_asid_o,
  output logic [`L2_TLB_TAG_LEN-1:0]  rd_tag_o,
  output logic [`L2_TLB_PPN_LEN-1:0]  rd_ppn_o,
  // Refill write
  input  logic                        wr_en_i,
  input  logic [`L2_TLB_IDX_LEN-1:0]  wr_idx_i,
  input  logic                        wr_global_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] wr_asid_i,
  input  logic [`L2_TLB_TAG_LEN-1:0]  wr_tag_i,
  input  logic [`L2_TLB_PPN_LEN-1:0]  wr_ppn_i,
  // Invalidate from t1
  input  logic                        inv_en_i,
  input  logic [`L2_TLB_IDX_LEN-1:0]  inv_idx_i
);

  localparam int unsigned NumSets = 1 << `L2_TLB_IDX_LEN;

  logic                        valid_q  [NumSets];
  logic                        global_q [NumSets];
  logic [`L2_TLB_ASID_LEN-1:0] asid_q   [NumSets];
  logic [`L2_TLB_TAG_LEN-1:0]  tag_q    [NumSets];
  logic [`L2_TLB_PPN_LEN-1:0]  ppn_q    [NumSets];

  // Valid bits, cleared by the reset flush walk
  always_ff @(posedge clk_i) begin
    if (inv_en_i) begin
      valid_q[inv_idx_i] <= 1'b0;
    end else if (wr_en_i) begin
      valid_q[wr_idx_i] <= 1'b1;
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      global_q[wr_idx_i] <= wr_global_i;
      asid_q[wr_idx_i]   <= wr_asid_i;
      tag_q[wr_idx_i]    <= wr_tag_i;
      ppn_q[wr_idx_i]    <= wr_ppn_i;
    end
  end

  // Read valid flag starts cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= valid_q[rd_idx_i];
    end
  end

  // Read data
  always_ff @(posedge clk_i) begin
    rd_global_o <= global_q[rd_idx_i];
    rd_asid_o   <= asid_q[rd_idx_i];
    rd_tag_o    <= tag_q[rd_idx_i];
    rd_ppn_o    <= ppn_q[rd_idx_i];
  end

endmodule

// File: source/l2_tlb_t0_stage.sv
// ############################
// L2 TLB stage t0
// Arbitrates flush, refill and lookup
// Drives the array and the t1 register
// ############################

`include "tlb_params.svh"

module l2_tlb_t0_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // External flush operands
  input  tlb_cmd_pkg::tlb_flush_e     flush_type_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] flush_asid_i,
  input  tlb_addr_pkg::l2_vpn_u       flush_vpn_i,
  // Refill strobe and entry
  input  logic                        refill_valid_i,
  input  tlb_addr_pkg::l2_vpn_u       refill_vpn_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] refill_asid_i,
  input  logic [`L2_TLB_PPN_LEN-1:0]  refill_ppn_i,
  input  logic                        refill_global_i,
  // Lookup strobe
  input  logic                        lookup_valid_i,
  input  tlb_addr_pkg::l2_vpn_u       lookup_vpn_i,
  input  logic [`L2_TLB_ASID_LEN-1:0] lookup_asid_i,
  // From the flush unit
  input  logic                        flush_req_valid_i,
  input  tlb_cmd_pkg::tlb_flush_e     flush_req_type_i,
  input  logic [`L2_TLB_IDX_LEN-1:0]  flush_idx_i,
  output logic                        flush_idx_cnt_en_o,
  // Array read and refill write
  output logic [`L2_TLB_IDX_LEN-1:0]  rd_idx_o,
  output logic                        wr_en_o,
  output logic [`L2_TLB_IDX_LEN-1:0]  wr_idx_o,
  output logic                        wr_global_o,
  output logic [`L2_TLB_ASID_LEN-1:0] wr_asid_o,
  output logic [`L2_TLB_TAG_LEN-1:0]  wr_tag_o,
  output logic [`L2_TLB_PPN_LEN-1:0]  wr_ppn_o,
  // Stage register, op is {lookup, flush type}
  output logic [2:0]                  t1_op_o,
  output logic [`L2_TLB_TAG_LEN-1:0]  t1_tag_o,
  output logic [`L2_TLB_ASID_LEN-1:0] t1_asid_o,
  output tlb_addr_pkg::l2_vpn_u       t1_flush_vpn_o,
  output logic [`L2_TLB_IDX_LEN-1:0]  t1_idx_o,
  output logic                        busy_o
);

  import tlb_cmd_pkg::*;

  logic [`L2_TLB_ASID_LEN-1:0] flush_asid_q;
  tlb_addr_pkg::l2_vpn_u       flush_vpn_q;
  logic                        t1_flush;
  logic                        lookup_go;
  logic [2:0]                  op_d;

  // Walk in progress or last invalidation still in t1
  assign t1_flush = (t1_op_o[1:0] != NoFlush);
  assign busy_o   = flush_req_valid_i | t1_flush;

  // Every issued flush op moves the walk on
  assign flush_idx_cnt_en_o = flush_req_valid_i;

  // Capture operands when a flush is requested from idle
  always_ff @(posedge clk_i) begin
    if (!flush_req_valid_i && (flush_type_i != NoFlush)) begin
      flush_asid_q <= flush_asid_i;
      flush_vpn_q  <= flush_vpn_i;
    end
  end

  // Requests while busy are dropped
  assign lookup_go = lookup_valid_i & ~busy_o;

  // Refill goes straight to the write port
  assign wr_en_o     = refill_valid_i & ~busy_o;
  assign wr_idx_o    = refill_vpn_i.fields.idx;
  assign wr_tag_o    = refill_vpn_i.fields.tag;
  assign wr_global_o = refill_global_i;
  assign wr_asid_o   = refill_asid_i;
  assign wr_ppn_o    = refill_ppn_i;

  // Flush walk owns the read port
  always_comb begin
    op_d     = 3'b000;
    rd_idx_o = lookup_vpn_i.fields.idx;
    if (flush_req_valid_i) begin
      op_d     = {1'b0, flush_req_type_i};
      rd_idx_o = flush_idx_i;
    end else if (lookup_go) begin
      op_d = {1'b1, NoFlush};
    end
  end

  // Op kind is control
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      t1_op_o <= 3'b000;
    end else begin
      t1_op_o <= op_d;
    end
  end

  // Operands for the compare in t1
  always_ff @(posedge clk_i) begin
    t1_idx_o  <= rd_idx_o;
    t1_tag_o  <= lookup_vpn_i.fields.tag;
    t1_asid_o <= flush_req_valid_i ? flush_asid_q : lookup_asid_i;
  end

  // Held for the whole walk
  assign t1_flush_vpn_o = flush_vpn_q;

endmodule

// File: source/l2_tlb_flush_unit.sv
// ############################
// L2 TLB flush unit
// Holds the active flush kind and
// walks the set index for t0
// Starts a total flush out of reset
// ############################

`include "tlb_params.svh"

module l2_tlb_flush_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Requested flush, sampled while idle
  input  tlb_cmd_pkg::tlb_flush_e   flush_type_i,
  // Advance to the next set
  input  logic                      flush_idx_cnt_en_i,
  // Set currently being flushed
  output logic [`L2_TLB_IDX_LEN-1:0] flush_idx_o,
  // Flush request towards t0
  output tlb_cmd_pkg::tlb_flush_e   flush_type_o,
  output logic                      flush_req_valid_o
);

  import tlb_cmd_pkg::*;

  // State encoding
  localparam logic [1:0] StIdle          = 2'd0;
  localparam logic [1:0] StTotalFlushing = 2'd1;
  localparam logic [1:0] StASIDFlushing  = 2'd2;
  localparam logic [1:0] StPageFlushing  = 2'd3;

  logic [1:0] state_d, state_q;

  logic [`L2_TLB_IDX_LEN-1:0] flush_idx_q;
  logic last_set;
  logic flush_end;

  assign flush_idx_o = flush_idx_q;

  // Set counter, wraps to zero after the last set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_idx_q <= '0;
    end else if (flush_idx_cnt_en_i) begin
      flush_idx_q <= flush_idx_q + 1'b1;
    end
  end

  // Last set addressed
  assign last_set  = &flush_idx_q;
  // Walk ends when the last set is issued
  assign flush_end = flush_idx_cnt_en_i & last_set;

  // Next state and request outputs
  always_comb begin
    state_d           = state_q;
    flush_type_o      = NoFlush;
    flush_req_valid_o = 1'b0;
    case (state_q)
      StIdle: begin
        // New flush only starts from idle
        case (flush_type_i)
          FlushAll:  state_d = StTotalFlushing;
          FlushASID: state_d = StASIDFlushing;
          FlushPage: state_d = StPageFlushing;
          default:   state_d = StIdle;
        endcase
      end
      StTotalFlushing: begin
        flush_type_o      = FlushAll;
        flush_req_valid_o = 1'b1;
      end
      StASIDFlushing: begin
        flush_type_o      = FlushASID;
        flush_req_valid_o = 1'b1;
      end
      StPageFlushing: begin
        flush_type_o      = FlushPage;
        flush_req_valid_o = 1'b1;
      end
      default: begin
        state_d = StIdle;
      end
    endcase
    // Back to idle once every set is counted
    if (flush_end) begin
      state_d = StIdle;
    end
  end

  // Reset enters the total flush, clearing all valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StTotalFlushing;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: source/tlb_addr_pkg.sv
// ############################
// L2 TLB address types
// Virtual page number seen either
// as one word or as tag over index
// ############################

`include "tlb_params.svh"

package tlb_addr_pkg;

  // Two views of the same page number
  // Whole word for page flush compares
  // Tag and set index for lookup and refill
  typedef union packed {
    logic [`L2_TLB_VPN_LEN-1:0] vpn;
    struct packed {
      // Upper part, stored in the entry
      logic [`L2_TLB_TAG_LEN-1:0] tag;
      // Lower part, selects the set
      logic [`L2_TLB_IDX_LEN-1:0] idx;
    } fields;
  } l2_vpn_u;

endpackage

// File: source/tlb_cmd_pkg.sv
// ############################
// L2 TLB command types
// Flush request encoding shared by
// the flush unit and the stages
// ############################

package tlb_cmd_pkg;

  // Flush kinds, NoFlush means no request
  typedef enum logic [1:0] {
    NoFlush,
    FlushAll,
    FlushASID,
    FlushPage
  } tlb_flush_e;

endpackage

// File: source/tlb_params.svh
// ############################
// L2 TLB width parameters
// Set index, page number, physical
// page number and ASID widths
// ############################

`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// Number of sets is 2**L2_TLB_IDX_LEN
`define L2_TLB_IDX_LEN 4
`define L2_TLB_VPN_LEN 20
`define L2_TLB_PPN_LEN 20
`define L2_TLB_ASID_LEN 8
// Tag is what is left of the VPN above the index
`define L2_TLB_TAG_LEN (`L2_TLB_VPN_LEN - `L2_TLB_IDX_LEN)

`endif
